// ==== Makefile ====
# Verilator flow for the query patch buffer
# sim exits non-zero when the testbench stops with $fatal

TOP := query_patch_buffer_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100

clean:
	rm -rf obj_dir

// ==== logic/patch_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared sizes and the ram word layout for the query patch buffer
// pix_credits must be a power of two; the pixel fifo pointers wrap freely
// mem_depth must be a whole number of banks of bank_depth entries
////////////////////////////////////////////////////////////////////////////

package patch_pkg;

  // pixel and patch geometry
  localparam int pix_w = 11;
  localparam int patch_pix = 5;
  localparam int patch_w = pix_w * patch_pix;

  // patch store
  localparam int mem_depth = 512;
  localparam int addr_w = $clog2(mem_depth);
  localparam int bank_depth = 256;
  localparam int bank_addr_w = $clog2(bank_depth);
  localparam int num_banks = mem_depth / bank_depth;
  localparam int lane_w = 32;
  localparam int pad_w = 2 * lane_w - patch_w;
  // macro read plus output register
  localparam int rd_lat = 2;

  // link credits
  localparam int pix_credits = 4;
  localparam int out_credits = 2;

  // derived counter widths
  localparam int fifo_ptr_w = $clog2(pix_credits);
  localparam int fifo_cnt_w = $clog2(pix_credits + 1);
  localparam int pix_cnt_w = $clog2(patch_pix);
  localparam int cred_w = $clog2(out_credits + 1);

  // one ram word, seen as pixels or as the two macro lanes
  typedef union packed {
    struct packed {
      logic [pad_w-1:0]                 pad;
      // pixel 0 sits in the lowest bits
      logic [patch_pix-1:0][pix_w-1:0]  pix;
    } px;
    struct packed {
      logic [lane_w-1:0] hi;
      logic [lane_w-1:0] lo;
    } lanes;
  } patch_word_u;

endpackage

// ==== logic/query_patch_buffer.sv ====
////////////////////////////////////////////////////////////////////////////
// query patch buffer top
// pixels in on a credit link, patches out on a credit link
// holds up to 512 patches; load_clear restarts loading and reading
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module query_patch_buffer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              load_clear,
  // pixel link
  input  logic                              pix_valid,
  input  logic [patch_pkg::pix_w-1:0]       pix_data,
  output logic                              pix_credit,
  output logic                              mem_full,
  // patch link
  output logic                              out_valid,
  output logic [patch_pkg::patch_w-1:0]     out_patch,
  input  logic                              out_credit
);

  // loader to memory
  logic                              wr_en;
  logic [patch_pkg::addr_w-1:0]      wr_addr;
  logic [patch_pkg::patch_w-1:0]     wr_patch;
  // loader to fetch
  logic [patch_pkg::addr_w:0]        fill_count;
  // fetch to memory and back
  logic                              rd_en;
  logic [patch_pkg::addr_w-1:0]      rd_addr;
  logic [patch_pkg::patch_w-1:0]     rd_patch;

  query_patch_loader u_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_clear (load_clear),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .pix_credit (pix_credit),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_patch   (wr_patch),
    .fill_count (fill_count),
    .mem_full   (mem_full)
  );

  query_patch_mem u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_patch (wr_patch),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_patch (rd_patch)
  );

  query_patch_fetch u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_clear (load_clear),
    .fill_count (fill_count),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_patch   (rd_patch),
    .out_valid  (out_valid),
    .out_patch  (out_patch),
    .out_credit (out_credit)
  );

endmodule

// ==== logic/query_patch_fetch.sv ====
////////////////////////////////////////////////////////////////////////////
// in-order reader of stored patches toward the credit output link
// out_valid follows rd_en by the fixed memory read latency
// load_clear drops reads in flight and gives their credits back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module query_patch_fetch (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              load_clear,
  // patches stored so far
  input  logic [patch_pkg::addr_w:0]        fill_count,
  // memory read port
  output logic                              rd_en,
  output logic [patch_pkg::addr_w-1:0]      rd_addr,
  input  logic [patch_pkg::patch_w-1:0]     rd_patch,
  // output link
  output logic                              out_valid,
  output logic [patch_pkg::patch_w-1:0]     out_patch,
  input  logic                              out_credit
);

  // credits held toward the consumer
  logic [patch_pkg::cred_w-1:0] cred_q;
  // credits of flushed reads
  logic [patch_pkg::cred_w-1:0] cred_back;
  // next patch to read
  logic [patch_pkg::addr_w:0]   rd_ptr;
  // reads in flight, one bit per memory stage
  logic [patch_pkg::rd_lat-1:0] vld_q;

  // issue while a credit is held and data is stored
  assign rd_en = (cred_q != '0) && (rd_ptr < fill_count) && !load_clear;
  assign rd_addr = rd_ptr[patch_pkg::addr_w-1:0];

  // the last stage is suppressed by a clear too
  assign out_valid = vld_q[patch_pkg::rd_lat-1] && !load_clear;
  // memory output register already holds the patch
  assign out_patch = rd_patch;

  // count reads dropped by a clear
  always_comb begin
    cred_back = '0;
    if (load_clear) begin
      for (int i = 0; i < patch_pkg::rd_lat; i++) begin
        cred_back = cred_back + patch_pkg::cred_w'(vld_q[i]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cred_q <= patch_pkg::cred_w'(patch_pkg::out_credits);
      rd_ptr <= '0;
      vld_q  <= '0;
    end else begin
      // returned, restored and spent credits in one step
      cred_q <= cred_q + patch_pkg::cred_w'(out_credit) + cred_back
                - patch_pkg::cred_w'(rd_en);
      if (load_clear) begin
        rd_ptr <= '0;
        vld_q  <= '0;
      end else begin
        if (rd_en) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        // valid walks with the read through the memory
        vld_q <= {vld_q[patch_pkg::rd_lat-2:0], rd_en};
      end
    end
  end

endmodule

// ==== logic/query_patch_loader.sv ====
////////////////////////////////////////////////////////////////////////////
// pixel credit receiver and patch assembler
// sender must respect credits; the fifo has no overflow check
// stops popping once 512 patches are stored, until load_clear
// credits of pixels dropped by load_clear come back one per cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module query_patch_loader (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              load_clear,
  // pixel link
  input  logic                              pix_valid,
  input  logic [patch_pkg::pix_w-1:0]       pix_data,
  output logic                              pix_credit,
  // write port
  output logic                              wr_en,
  output logic [patch_pkg::addr_w-1:0]      wr_addr,
  output logic [patch_pkg::patch_w-1:0]     wr_patch,
  // status
  output logic [patch_pkg::addr_w:0]        fill_count,
  output logic                              mem_full
);

  // pixel fifo
  logic [patch_pkg::pix_w-1:0]      fifo_mem [patch_pkg::pix_credits];
  logic [patch_pkg::fifo_ptr_w-1:0] fifo_wr_ptr;
  logic [patch_pkg::fifo_ptr_w-1:0] fifo_rd_ptr;
  logic [patch_pkg::fifo_cnt_w-1:0] fifo_cnt;
  // credits owed after a clear
  logic [patch_pkg::fifo_cnt_w-1:0] ret_cnt;
  logic [patch_pkg::fifo_cnt_w-1:0] ret_add;

  // assembly
  logic [patch_pkg::pix_cnt_w-1:0]                    pix_cnt;
  logic [patch_pkg::patch_pix-1:0][patch_pkg::pix_w-1:0] asm_q;
  logic [patch_pkg::patch_pix-1:0][patch_pkg::pix_w-1:0] asm_next;
  logic [patch_pkg::addr_w:0]                          wr_cnt;

  logic push;
  logic pop;

  assign push = pix_valid && !load_clear;
  assign mem_full = (wr_cnt == patch_pkg::mem_depth);
  // no pops while owed credits drain, keeps one pulse per cycle
  assign pop = (fifo_cnt != '0) && !mem_full && !load_clear && (ret_cnt == '0);
  assign pix_credit = pop || (ret_cnt != '0);

  // newest pixel enters at the top, pixel 0 ends up lowest
  assign asm_next = {fifo_mem[fifo_rd_ptr], asm_q[patch_pkg::patch_pix-1:1]};

  // fifth pixel writes on its pop cycle
  assign wr_en = pop && (pix_cnt == patch_pkg::pix_cnt_w'(patch_pkg::patch_pix - 1));
  assign wr_addr = wr_cnt[patch_pkg::addr_w-1:0];
  assign wr_patch = asm_next;
  assign fill_count = wr_cnt;

  // everything in the fifo plus a pixel landing on the clear cycle
  assign ret_add = load_clear ? fifo_cnt + patch_pkg::fifo_cnt_w'(pix_valid) : '0;

  // fifo storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[fifo_wr_ptr] <= pix_data;
    end
    if (pop) begin
      asm_q <= asm_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_wr_ptr <= '0;
      fifo_rd_ptr <= '0;
      fifo_cnt    <= '0;
      ret_cnt     <= '0;
      pix_cnt     <= '0;
      wr_cnt      <= '0;
    end else begin
      ret_cnt <= ret_cnt - patch_pkg::fifo_cnt_w'(ret_cnt != '0) + ret_add;
      if (load_clear) begin
        fifo_wr_ptr <= '0;
        fifo_rd_ptr <= '0;
        fifo_cnt    <= '0;
        pix_cnt     <= '0;
        wr_cnt      <= '0;
      end else begin
        fifo_wr_ptr <= fifo_wr_ptr + patch_pkg::fifo_ptr_w'(push);
        fifo_rd_ptr <= fifo_rd_ptr + patch_pkg::fifo_ptr_w'(pop);
        fifo_cnt <= fifo_cnt + patch_pkg::fifo_cnt_w'(push) - patch_pkg::fifo_cnt_w'(pop);
        // group position
        if (wr_en) begin
          pix_cnt <= '0;
          wr_cnt  <= wr_cnt + 1'b1;
        end else if (pop) begin
          pix_cnt <= pix_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/query_patch_mem.sv ====
////////////////////////////////////////////////////////////////////////////
// 512 entry patch store, two banks of two 32-bit macros
// top address bit picks the bank; upper nine bits of each word are padding
// rd_patch is valid two cycles after rd_en and holds until the next read
// no read-back on the write port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module query_patch_mem (
  input  logic                              clk,
  input  logic                              rst_n,
  // write side
  input  logic                              wr_en,
  input  logic [patch_pkg::addr_w-1:0]      wr_addr,
  input  logic [patch_pkg::patch_w-1:0]     wr_patch,
  // read side
  input  logic                              rd_en,
  input  logic [patch_pkg::addr_w-1:0]      rd_addr,
  output logic [patch_pkg::patch_w-1:0]     rd_patch
);

  // bank bits of both addresses
  logic wr_bank;
  logic rd_bank;
  // registered read bank, lines up with macro output
  logic rd_bank_q;
  logic rd_en_q;

  // active-low bank selects
  logic [patch_pkg::num_banks-1:0] wr_sel_n;
  logic [patch_pkg::num_banks-1:0] rd_sel_n;

  patch_pkg::patch_word_u wr_word;
  patch_pkg::patch_word_u rd_word;

  // macro outputs per bank
  logic [patch_pkg::lane_w-1:0] rd_hi [patch_pkg::num_banks];
  logic [patch_pkg::lane_w-1:0] rd_lo [patch_pkg::num_banks];

  assign wr_bank = wr_addr[patch_pkg::addr_w-1];
  assign rd_bank = rd_addr[patch_pkg::addr_w-1];

  // pixel view in, zero pad on top
  always_comb begin
    wr_word = '0;
    wr_word.px.pix = wr_patch;
  end

  for (genvar b = 0; b < patch_pkg::num_banks; b++) begin : g_bank
    // only the addressed bank is enabled
    assign wr_sel_n[b] = !(wr_en && (wr_bank == b));
    assign rd_sel_n[b] = !(rd_en && (rd_bank == b));

    // low lane
    sram_1rw1r u_lo (
      .clk   (clk),
      .csb0  (wr_sel_n[b]),
      .web0  (wr_sel_n[b]),
      .addr0 (wr_addr[patch_pkg::bank_addr_w-1:0]),
      .din0  (wr_word.lanes.lo),
      .dout0 (),
      .csb1  (rd_sel_n[b]),
      .addr1 (rd_addr[patch_pkg::bank_addr_w-1:0]),
      .dout1 (rd_lo[b])
    );

    // high lane, carries the padding
    sram_1rw1r u_hi (
      .clk   (clk),
      .csb0  (wr_sel_n[b]),
      .web0  (wr_sel_n[b]),
      .addr0 (wr_addr[patch_pkg::bank_addr_w-1:0]),
      .din0  (wr_word.lanes.hi),
      .dout0 (),
      .csb1  (rd_sel_n[b]),
      .addr1 (rd_addr[patch_pkg::bank_addr_w-1:0]),
      .dout1 (rd_hi[b])
    );
  end

  // remember which bank answers next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en_q   <= 1'b0;
      rd_bank_q <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
      if (rd_en) begin
        rd_bank_q <= rd_bank;
      end
    end
  end

  // lanes from the right bank
  always_comb begin
    rd_word.lanes.hi = rd_hi[rd_bank_q];
    rd_word.lanes.lo = rd_lo[rd_bank_q];
  end

  // output register, pad dropped
  always_ff @(posedge clk) begin
    if (rd_en_q) begin
      rd_patch <= rd_word.px.pix;
    end
  end

endmodule

// ==== logic/sram_1rw1r.sv ====
////////////////////////////////////////////////////////////////////////////
// behavioral stand-in for a 32x256 dual port sram macro
// port 0 reads or writes, port 1 only reads; all selects active low
// no write mask, the full word is always written
// same-cycle write and read of one address returns the old word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_1rw1r (
  input  logic                                clk,
  // port 0, read/write
  input  logic                                csb0,
  input  logic                                web0,
  input  logic [patch_pkg::bank_addr_w-1:0]   addr0,
  input  logic [patch_pkg::lane_w-1:0]        din0,
  output logic [patch_pkg::lane_w-1:0]        dout0,
  // port 1, read only
  input  logic                                csb1,
  input  logic [patch_pkg::bank_addr_w-1:0]   addr1,
  output logic [patch_pkg::lane_w-1:0]        dout1
);

  // storage array
  logic [patch_pkg::lane_w-1:0] mem [patch_pkg::bank_depth];

  // port 0
  // write when selected and web0 low, else registered read
  always_ff @(posedge clk) begin
    if (!csb0) begin
      if (!web0) begin
        mem[addr0] <= din0;
      end else begin
        dout0 <= mem[addr0];
      end
    end
  end

  // port 1
  // output holds while deselected
  always_ff @(posedge clk) begin
    if (!csb1) begin
      dout1 <= mem[addr1];
    end
  end

endmodule

// ==== tests/query_patch_buffer_assert.sv ====
////////////////////////////////////////////////////////////////////////////
// port checks for query_patch_buffer, bound from the testbench
// assumes a sender and consumer that keep to their credits
// fail_seen rises on any failed property and stays high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module query_patch_buffer_assert (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              load_clear,
  input  logic                              pix_valid,
  input  logic                              pix_credit,
  input  logic                              mem_full,
  input  logic                              out_valid,
  input  logic                              out_credit
);

  bit   fail_seen = 1'b0;
  // any pixel since reset
  logic pix_seen;
  // pixels sent and not yet credited
  int   pix_out;
  // patches received and not yet credited back
  int   patch_held;
  // patches out since reset or clear
  int   out_since_clear;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_seen        <= 1'b0;
      pix_out         <= 0;
      patch_held      <= 0;
      out_since_clear <= 0;
    end else begin
      pix_seen   <= pix_seen | pix_valid;
      pix_out    <= pix_out + int'(pix_valid) - int'(pix_credit);
      patch_held <= patch_held + int'(out_valid) - int'(out_credit);
      if (load_clear) begin
        out_since_clear <= 0;
      end else begin
        out_since_clear <= out_since_clear + int'(out_valid);
      end
    end
  end

  // link quiet until the first pixel
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !pix_seen |-> !pix_credit && !out_valid && !mem_full)
    else begin fail_seen = 1'b1; $error("activity on the outputs before any pixel"); end

  // pixel credits stay within the sender's allowance
  a_pix_window: assert property (@(posedge clk) disable iff (!rst_n)
    (pix_out + int'(pix_valid) <= patch_pkg::pix_credits) && (pix_out >= int'(pix_credit)))
    else begin fail_seen = 1'b1; $error("pixel credits out of range"); end

  // patches in the consumer's hands stay within its credits
  a_out_window: assert property (@(posedge clk) disable iff (!rst_n)
    (patch_held + int'(out_valid) <= patch_pkg::out_credits) && (patch_held >= int'(out_credit)))
    else begin fail_seen = 1'b1; $error("more patches sent than credits allow"); end

  // full store takes no pixels and holds until a clear
  a_full_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    mem_full |-> !pix_credit)
    else begin fail_seen = 1'b1; $error("pixel credit returned while the store was full"); end

  a_full_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    mem_full && !load_clear |=> mem_full)
    else begin fail_seen = 1'b1; $error("full flag dropped without a clear"); end

  a_clear_empty: assert property (@(posedge clk) disable iff (!rst_n)
    load_clear |=> !mem_full)
    else begin fail_seen = 1'b1; $error("full flag still set after a clear"); end

  a_out_bound: assert property (@(posedge clk) disable iff (!rst_n)
    out_since_clear <= patch_pkg::mem_depth)
    else begin fail_seen = 1'b1; $error("more patches out than the store holds"); end

endmodule

// ==== tests/query_patch_buffer_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for query_patch_buffer
// pixels are random, sent only against held credits, with idle cycles
// inputs change on the rising edge, everything is sampled on the falling
// port rules live in the bound assertion module
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module query_patch_buffer_tb;

  // about 4600 pixels at no less than 0.5 per cycle, plus drain, doubled
  localparam int timeout_cycles = 20000;

  logic                          clk;
  logic                          rst_n;
  logic                          load_clear;
  logic                          pix_valid;
  logic [patch_pkg::pix_w-1:0]   pix_data;
  logic                          pix_credit;
  logic                          mem_full;
  logic                          out_valid;
  logic [patch_pkg::patch_w-1:0] out_patch;
  logic                          out_credit;

  integer seed;
  int     cycle_cnt;
  // pixel link, sent versus credited
  int     to_send;
  int     pix_sent;
  int     pix_cred_got;
  // patch link, received versus credited back
  int     out_got;
  int     out_cred_ret;
  int     out_since_clear;
  // expected patches in write order, plus the group being built
  logic [patch_pkg::patch_w-1:0] exp_q [$];
  logic [patch_pkg::pix_w-1:0]   grp [patch_pkg::patch_pix];
  int                            grp_cnt;

  query_patch_buffer query_patch_buffer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_clear (load_clear),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .pix_credit (pix_credit),
    .mem_full   (mem_full),
    .out_valid  (out_valid),
    .out_patch  (out_patch),
    .out_credit (out_credit)
  );

  bind query_patch_buffer query_patch_buffer_assert query_patch_buffer_assert_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_clear (load_clear),
    .pix_valid  (pix_valid),
    .pix_credit (pix_credit),
    .mem_full   (mem_full),
    .out_valid  (out_valid),
    .out_credit (out_credit)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped on a failed check");
  endtask

  // one clock of stimulus on both links
  task automatic run_cycle(input bit may_send, input bit clear);
    int r;
    @(posedge clk);
    r = $random(seed);
    load_clear <= clear;
    if (may_send && !clear && to_send > 0 &&
        (pix_sent - pix_cred_got) < patch_pkg::pix_credits && r[1:0] != 2'b00) begin
      pix_valid <= 1'b1;
      pix_data  <= patch_pkg::pix_w'($random(seed));
      pix_sent++;
      to_send--;
    end else begin
      pix_valid <= 1'b0;
    end
    // credit back only for patches already received
    if (out_got > out_cred_ret && r[3]) begin
      out_credit <= 1'b1;
      out_cred_ret++;
    end else begin
      out_credit <= 1'b0;
    end
  endtask

  // clear pulse, then one idle cycle so the monitor sees it
  task automatic clear_store();
    run_cycle(1'b0, 1'b1);
    run_cycle(1'b0, 1'b0);
  endtask

  // scoreboard and link bookkeeping
  always @(negedge clk) begin
    logic [patch_pkg::patch_w-1:0] exp_patch;
    if (rst_n) begin
      if (pix_credit) begin
        pix_cred_got++;
      end
      if (load_clear) begin
        exp_q.delete();
        grp_cnt = 0;
        out_since_clear = 0;
      end else if (pix_valid) begin
        grp[grp_cnt] = pix_data;
        grp_cnt++;
        // pixel 0 goes in the lowest bits
        if (grp_cnt == patch_pkg::patch_pix) begin
          for (int i = 0; i < patch_pkg::patch_pix; i++) begin
            exp_patch[i*patch_pkg::pix_w +: patch_pkg::pix_w] = grp[i];
          end
          exp_q.push_back(exp_patch);
          grp_cnt = 0;
        end
      end
      if (out_valid) begin
        out_got++;
        out_since_clear++;
        assert (exp_q.size() != 0)
          else abort_run("a patch came out while none was expected");
        assert (out_patch === exp_q[0])
          else abort_run($sformatf("[ERROR] %0d ns: out_patch %h, expected %h",
                                   $time, out_patch, exp_q[0]));
        void'(exp_q.pop_front());
      end
    end
  end

  // raised by the bound port checks
  always @(negedge clk) begin
    if (query_patch_buffer_i.query_patch_buffer_assert_i.fail_seen) begin
      abort_run("a port assertion on the DUT failed");
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      abort_run("timeout: the run did not finish within the cycle limit");
    end
  end

  initial begin
    seed       = 32'h9ba6b958;
    clk        = 1'b0;
    rst_n      = 1'b0;
    load_clear = 1'b0;
    pix_valid  = 1'b0;
    pix_data   = '0;
    out_credit = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // idle links after reset
    repeat (20) run_cycle(1'b0, 1'b0);

    // fill all 512 entries, each read back in order
    to_send = patch_pkg::mem_depth * patch_pkg::patch_pix;
    while (out_since_clear < patch_pkg::mem_depth) begin
      run_cycle(1'b1, 1'b0);
    end
    @(negedge clk);
    assert (mem_full && exp_q.size() == 0)
      else abort_run("store not full after 512 complete patches");

    // extra pixels stay unacknowledged once full
    to_send = patch_pkg::pix_credits;
    repeat (40) run_cycle(1'b1, 1'b0);
    @(negedge clk);
    assert (pix_sent - pix_cred_got == patch_pkg::pix_credits &&
            out_since_clear == patch_pkg::mem_depth)
      else abort_run("pixels taken or patches sent after the store filled");

    // restart, 300 patches across the bank edge plus a partial group
    clear_store();
    to_send = 300 * patch_pkg::patch_pix + 3;
    while (out_since_clear < 300 || to_send != 0) begin
      run_cycle(1'b1, 1'b0);
    end

    // clear in mid stream, then only new patches may appear
    clear_store();
    to_send = 37;
    while (to_send != 0) begin
      run_cycle(1'b1, 1'b0);
    end
    clear_store();
    to_send = 100 * patch_pkg::patch_pix;
    while (out_since_clear < 100) begin
      run_cycle(1'b1, 1'b0);
    end

    @(negedge clk);
    if (exp_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("expected patches left over at the end of the run");
    end
  end

endmodule

// ==== verilog.f ====
logic/patch_pkg.sv
logic/sram_1rw1r.sv
logic/query_patch_mem.sv
logic/query_patch_loader.sv
logic/query_patch_fetch.sv
logic/query_patch_buffer.sv
tests/query_patch_buffer_assert.sv
tests/query_patch_buffer_tb.sv
